// ==== screen_params.svh ====
`ifndef SCREEN_PARAMS_SVH
`define SCREEN_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// 800x600 timing, counted in pixel clocks and lines
// ~~~~~~~~~~~~~~~~~~~~
`define H_ACTIVE        800
`define H_TOTAL         1056
`define H_SYNC_START    840
`define H_SYNC_END      968

`define V_ACTIVE        600
`define V_TOTAL         628
`define V_SYNC_START    601
`define V_SYNC_END      605

// ~~~~~~~~~~~~~~~~~~~~
// end screen geometry
// ~~~~~~~~~~~~~~~~~~~~
`define STRIPE_WIDTH     32
`define END_RECT_OUTER_W 40
`define END_RECT_OUTER_H 40
`define END_RECT_INNER_W 200
`define END_RECT_INNER_H 150

// ~~~~~~~~~~~~~~~~~~~~
// colours, 4 bits per channel in r g b order
// ~~~~~~~~~~~~~~~~~~~~
`define WHITE  12'hfff
`define YELLOW 12'hff0
`define RED    12'hf00
`define BLUE   12'h00f
`define GREEN  12'h0f0
`define BLACK  12'h000

`define RECT_LAYERS 3

`endif

// ==== screen_pkg.sv ====
`include "screen_params.svh"

package screen_pkg;

  // pixel position or count, wide enough for the full 1056 pixel line
  typedef logic [10:0] coord_t;

  typedef logic [11:0] rgb_t;

  // colour of one 32 pixel wide stripe of the end screen
  function automatic rgb_t stripe_rgb(input coord_t index);
    rgb_t colour;
    case (index)
      0, 4, 7, 9, 11, 14, 17, 21, 22: colour = `YELLOW;
      1, 5, 8, 13, 19:                colour = `RED;
      6, 15, 20:                      colour = `BLUE;
      3, 12, 18, 23:                  colour = `GREEN;
      2, 10, 16:                      colour = `BLACK;
      // the right edge of the screen and beyond stays red
      default:                        colour = `RED;
    endcase
    return colour;
  endfunction

endpackage

// ==== vga_timing.sv ====
`include "screen_params.svh"

module vga_timing import screen_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk
);

  coord_t hcount_nxt;
  coord_t vcount_nxt;
  logic   hsync_nxt;
  logic   vsync_nxt;
  logic   hblnk_nxt;
  logic   vblnk_nxt;

  // ~~~~~~~~~~~~~~~~~~~~
  // counters
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (hcount == coord_t'(`H_TOTAL - 1)) begin
      hcount_nxt = '0;
      if (vcount == coord_t'(`V_TOTAL - 1)) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vcount + coord_t'(1);
      end
    end else begin
      hcount_nxt = hcount + coord_t'(1);
      vcount_nxt = vcount;
    end
  end

  // syncs and blanks are decoded from the next count so that they
  // leave the register together with the count they belong to
  always_comb begin
    hsync_nxt = (hcount_nxt >= `H_SYNC_START) && (hcount_nxt < `H_SYNC_END);
    vsync_nxt = (vcount_nxt >= `V_SYNC_START) && (vcount_nxt < `V_SYNC_END);
    hblnk_nxt = (hcount_nxt >= `H_ACTIVE);
    vblnk_nxt = (vcount_nxt >= `V_ACTIVE);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= hcount_nxt;
      vcount <= vcount_nxt;
      hsync  <= hsync_nxt;
      vsync  <= vsync_nxt;
      hblnk  <= hblnk_nxt;
      vblnk  <= vblnk_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~

  count_range_a: assert property (
    @(posedge clk) disable iff (rst)
    (hcount < `H_TOTAL) && (vcount < `V_TOTAL)
  ) else $error("timing counter out of range h=%0d v=%0d", hcount, vcount);

endmodule

// ==== draw_screen_end.sv ====
`include "screen_params.svh"

module draw_screen_end import screen_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  coord_t in_hcount,
  input  coord_t in_vcount,
  input  logic   in_hsync,
  input  logic   in_vsync,
  input  logic   in_hblnk,
  input  logic   in_vblnk,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk,
  output rgb_t   rgb
);

  coord_t stripe_index;
  rgb_t   stripe_colour;
  logic   outside_frame;
  logic   inside_panel;
  rgb_t   rgb_nxt;

  // ~~~~~~~~~~~~~~~~~~~~
  // stripes
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    stripe_index  = coord_t'(in_hcount / `STRIPE_WIDTH);
    stripe_colour = stripe_rgb(stripe_index);
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // white frame and panel
  // ~~~~~~~~~~~~~~~~~~~~

  // the right edge column of the frame opening is still part of the stripes
  always_comb begin
    outside_frame = (in_hcount < `END_RECT_OUTER_W) ||
                    (in_hcount > (`H_ACTIVE - `END_RECT_OUTER_W)) ||
                    (in_vcount < `END_RECT_OUTER_H) ||
                    (in_vcount >= (`V_ACTIVE - `END_RECT_OUTER_H));
  end

  // the panel includes both of its edges in each direction
  always_comb begin
    inside_panel = (in_hcount >= `END_RECT_INNER_W) &&
                   (in_hcount <= (`H_ACTIVE - `END_RECT_INNER_W)) &&
                   (in_vcount >= `END_RECT_INNER_H) &&
                   (in_vcount <= (`V_ACTIVE - `END_RECT_INNER_H));
  end

  always_comb begin
    if (outside_frame || inside_panel) begin
      rgb_nxt = `WHITE;
    end else begin
      rgb_nxt = stripe_colour;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
      rgb    <= '0;
    end else begin
      hcount <= in_hcount;
      vcount <= in_vcount;
      hsync  <= in_hsync;
      vsync  <= in_vsync;
      hblnk  <= in_hblnk;
      vblnk  <= in_vblnk;
      rgb    <= rgb_nxt;
    end
  end

endmodule

// ==== draw_rect_layer.sv ====
`include "screen_params.svh"

module draw_rect_layer import screen_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  coord_t in_hcount,
  input  coord_t in_vcount,
  input  logic   in_hsync,
  input  logic   in_vsync,
  input  logic   in_hblnk,
  input  logic   in_vblnk,
  input  rgb_t   in_rgb,
  input  logic   rect_en,
  input  coord_t rect_x,
  input  coord_t rect_y,
  input  coord_t rect_w,
  input  coord_t rect_h,
  input  rgb_t   rect_rgb,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk,
  output rgb_t   rgb
);

  logic         frame_start;
  logic         en_q;
  coord_t       x_q;
  coord_t       y_q;
  coord_t       w_q;
  coord_t       h_q;
  rgb_t         rgb_q;
  logic         cur_en;
  coord_t       cur_x;
  coord_t       cur_y;
  logic [11:0]  x_end;
  logic [11:0]  y_end;
  logic         hit;

  assign frame_start = (in_hcount == '0) && (in_vcount == '0);

  // geometry for the whole frame is taken at its first pixel
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
    end else if (frame_start) begin
      en_q <= rect_en;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      x_q   <= rect_x;
      y_q   <= rect_y;
      w_q   <= rect_w;
      h_q   <= rect_h;
      rgb_q <= rect_rgb;
    end
  end

  // the first pixel already sees the values being latched
  always_comb begin
    cur_en = frame_start ? rect_en : en_q;
    cur_x  = frame_start ? rect_x : x_q;
    cur_y  = frame_start ? rect_y : y_q;
    x_end  = {1'b0, cur_x} + {1'b0, (frame_start ? rect_w : w_q)};
    y_end  = {1'b0, cur_y} + {1'b0, (frame_start ? rect_h : h_q)};
    hit    = cur_en &&
             (in_hcount >= cur_x) && ({1'b0, in_hcount} < x_end) &&
             (in_vcount >= cur_y) && ({1'b0, in_vcount} < y_end);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
      rgb    <= '0;
    end else begin
      hcount <= in_hcount;
      vcount <= in_vcount;
      hsync  <= in_hsync;
      vsync  <= in_vsync;
      hblnk  <= in_hblnk;
      vblnk  <= in_vblnk;
      rgb    <= hit ? (frame_start ? rect_rgb : rgb_q) : in_rgb;
    end
  end

  timing_delay_a: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |->
      ({hcount, vcount, hsync, vsync, hblnk, vblnk} ==
       $past({in_hcount, in_vcount, in_hsync, in_vsync, in_hblnk, in_vblnk}))
  ) else $error("layer timing is not a one cycle copy of its inputs");

endmodule

// ==== vga_out.sv ====
`include "screen_params.svh"

module vga_out import screen_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  coord_t in_hcount,
  input  coord_t in_vcount,
  input  logic   in_hsync,
  input  logic   in_vsync,
  input  logic   in_hblnk,
  input  logic   in_vblnk,
  input  rgb_t   in_rgb,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk,
  output rgb_t   rgb
);

  rgb_t rgb_nxt;

  // the monitor expects black outside the visible area
  always_comb begin
    if (in_hblnk || in_vblnk) begin
      rgb_nxt = `BLACK;
    end else begin
      rgb_nxt = in_rgb;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
      rgb    <= '0;
    end else begin
      hcount <= in_hcount;
      vcount <= in_vcount;
      hsync  <= in_hsync;
      vsync  <= in_vsync;
      hblnk  <= in_hblnk;
      vblnk  <= in_vblnk;
      rgb    <= rgb_nxt;
    end
  end

endmodule

// ==== screen_end_top.sv ====
`include "screen_params.svh"

module screen_end_top import screen_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   rect_en  [`RECT_LAYERS],
  input  coord_t rect_x   [`RECT_LAYERS],
  input  coord_t rect_y   [`RECT_LAYERS],
  input  coord_t rect_w   [`RECT_LAYERS],
  input  coord_t rect_h   [`RECT_LAYERS],
  input  rgb_t   rect_rgb [`RECT_LAYERS],
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   hblnk,
  output logic   vblnk,
  output rgb_t   rgb
);

  coord_t tim_hcount;
  coord_t tim_vcount;
  logic   tim_hsync;
  logic   tim_vsync;
  logic   tim_hblnk;
  logic   tim_vblnk;

  // entry 0 is the background, entry i+1 the output of layer i
  coord_t chain_hcount [`RECT_LAYERS+1];
  coord_t chain_vcount [`RECT_LAYERS+1];
  logic   chain_hsync  [`RECT_LAYERS+1];
  logic   chain_vsync  [`RECT_LAYERS+1];
  logic   chain_hblnk  [`RECT_LAYERS+1];
  logic   chain_vblnk  [`RECT_LAYERS+1];
  rgb_t   chain_rgb    [`RECT_LAYERS+1];

  vga_timing u_vga_timing (
    .clk(clk), .rst(rst),
    .hcount(tim_hcount), .vcount(tim_vcount),
    .hsync(tim_hsync), .vsync(tim_vsync), .hblnk(tim_hblnk), .vblnk(tim_vblnk)
  );

  draw_screen_end u_draw_screen_end (
    .clk(clk), .rst(rst),
    .in_hcount(tim_hcount), .in_vcount(tim_vcount),
    .in_hsync(tim_hsync), .in_vsync(tim_vsync),
    .in_hblnk(tim_hblnk), .in_vblnk(tim_vblnk),
    .hcount(chain_hcount[0]), .vcount(chain_vcount[0]),
    .hsync(chain_hsync[0]), .vsync(chain_vsync[0]),
    .hblnk(chain_hblnk[0]), .vblnk(chain_vblnk[0]), .rgb(chain_rgb[0])
  );

  // later layers sit on top, so the highest index wins on overlap
  for (genvar i = 0; i < `RECT_LAYERS; i++) begin : g_layer
    draw_rect_layer u_layer (
      .clk(clk), .rst(rst),
      .in_hcount(chain_hcount[i]), .in_vcount(chain_vcount[i]),
      .in_hsync(chain_hsync[i]), .in_vsync(chain_vsync[i]),
      .in_hblnk(chain_hblnk[i]), .in_vblnk(chain_vblnk[i]), .in_rgb(chain_rgb[i]),
      .rect_en(rect_en[i]), .rect_x(rect_x[i]), .rect_y(rect_y[i]),
      .rect_w(rect_w[i]), .rect_h(rect_h[i]), .rect_rgb(rect_rgb[i]),
      .hcount(chain_hcount[i+1]), .vcount(chain_vcount[i+1]),
      .hsync(chain_hsync[i+1]), .vsync(chain_vsync[i+1]),
      .hblnk(chain_hblnk[i+1]), .vblnk(chain_vblnk[i+1]), .rgb(chain_rgb[i+1])
    );
  end

  vga_out u_vga_out (
    .clk(clk), .rst(rst),
    .in_hcount(chain_hcount[`RECT_LAYERS]), .in_vcount(chain_vcount[`RECT_LAYERS]),
    .in_hsync(chain_hsync[`RECT_LAYERS]), .in_vsync(chain_vsync[`RECT_LAYERS]),
    .in_hblnk(chain_hblnk[`RECT_LAYERS]), .in_vblnk(chain_vblnk[`RECT_LAYERS]),
    .in_rgb(chain_rgb[`RECT_LAYERS]),
    .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb)
  );

endmodule

// ==== screen_end_tb.sv ====
`include "screen_params.svh"

module screen_end_tb import screen_pkg::*; ();

  localparam string TESTS_FILE = "screen_end_tests.txt";

  logic   clk;
  logic   rst;
  logic   rect_en  [`RECT_LAYERS];
  coord_t rect_x   [`RECT_LAYERS];
  coord_t rect_y   [`RECT_LAYERS];
  coord_t rect_w   [`RECT_LAYERS];
  coord_t rect_h   [`RECT_LAYERS];
  rgb_t   rect_rgb [`RECT_LAYERS];
  coord_t hcount;
  coord_t vcount;
  logic   hsync;
  logic   vsync;
  logic   hblnk;
  logic   vblnk;
  rgb_t   rgb;

  // layer settings of the frame record being applied
  int new_en  [`RECT_LAYERS];
  int new_x   [`RECT_LAYERS];
  int new_y   [`RECT_LAYERS];
  int new_w   [`RECT_LAYERS];
  int new_h   [`RECT_LAYERS];
  int new_rgb [`RECT_LAYERS];

  int check_count = 0;
  int error_count = 0;
  int cycle_count = 0;
  // one frame for the start, one more per frame record read
  int cycle_limit = `H_TOTAL * `V_TOTAL;

  screen_end_top screen_end_top_inst (
    .clk(clk), .rst(rst),
    .rect_en(rect_en), .rect_x(rect_x), .rect_y(rect_y),
    .rect_w(rect_w), .rect_h(rect_h), .rect_rgb(rect_rgb),
    .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
    .hblnk(hblnk), .vblnk(vblnk), .rgb(rgb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checking and reporting
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("%0d checks done, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // hsync, vsync, hblnk and vblnk packed in that order for one output pixel
  function automatic logic [3:0] expected_flags(input int x, input int y);
    logic [3:0] flags;
    flags[3] = (x >= `H_SYNC_START) && (x < `H_SYNC_END);
    flags[2] = (y >= `V_SYNC_START) && (y < `V_SYNC_END);
    flags[1] = (x >= `H_ACTIVE);
    flags[0] = (y >= `V_ACTIVE);
    return flags;
  endfunction

  // syncs and blanks belong to the count presented with them
  always @(negedge clk) begin
    if (!rst) begin
      check_value({hsync, vsync, hblnk, vblnk}, expected_flags(hcount, vcount),
                  "sync and blank flags");
    end
  end

  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    error_count++;
    $display("timeout: the probes were not all reached within %0d cycles", cycle_limit);
    finish_run();
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic bit read_layers(input int fd);
    int l;
    int n;
    bit ok;
    ok = 1'b1;
    for (l = 0; l < `RECT_LAYERS; l++) begin
      n = $fscanf(fd, " %d %d %d %d %d %h", new_en[l], new_x[l], new_y[l],
                  new_w[l], new_h[l], new_rgb[l]);
      if (n != 6) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic wait_for_line(input int lo, input int hi);
    @(negedge clk);
    while (vcount < lo || vcount > hi) begin
      @(negedge clk);
    end
  endtask

  task automatic apply_rects();
    int l;
    @(posedge clk);
    for (l = 0; l < `RECT_LAYERS; l++) begin
      rect_en[l]  <= (new_en[l] != 0);
      rect_x[l]   <= coord_t'(new_x[l]);
      rect_y[l]   <= coord_t'(new_y[l]);
      rect_w[l]   <= coord_t'(new_w[l]);
      rect_h[l]   <= coord_t'(new_h[l]);
      rect_rgb[l] <= rgb_t'(new_rgb[l]);
    end
  endtask

  task automatic probe_pixel(input int x, input int y, input int expected);
    @(negedge clk);
    while (hcount != x || vcount != y) begin
      @(negedge clk);
    end
    check_value(rgb, expected, $sformatf("rgb at x=%0d y=%0d", x, y));
  endtask

  task automatic run_records(input int fd);
    string code;
    string skip;
    int    row;
    int    px;
    int    py;
    int    pexp;
    bit    done;
    done = 1'b0;
    while (!done) begin
      if ($fscanf(fd, " %s", code) != 1) begin
        done = 1'b1;
      end else if (code[0] == "#") begin
        void'($fgets(skip, fd));
      end else if (code == "F" || code == "M") begin
        if (!read_layers(fd) || (code == "M" && $fscanf(fd, " %d", row) != 1)) begin
          error_count++;
          $display("malformed %s record in %s", code, TESTS_FILE);
          done = 1'b1;
        end else begin
          cycle_limit += `H_TOTAL * `V_TOTAL;
          // an M record changes the inputs in the middle of the current frame
          if (code == "M") begin
            wait_for_line(row, row);
          end else begin
            wait_for_line(`V_ACTIVE, `V_TOTAL - 2);
          end
          apply_rects();
        end
      end else if (code == "P" && $fscanf(fd, " %d %d %h", px, py, pexp) == 3) begin
        probe_pixel(px, py, pexp);
      end else begin
        error_count++;
        $display("unreadable record starting with %s in %s", code, TESTS_FILE);
        done = 1'b1;
      end
    end
  endtask

  initial begin
    int l;
    int fd;
    rst = 1'b1;
    for (l = 0; l < `RECT_LAYERS; l++) begin
      rect_en[l]  = 1'b0;
      rect_x[l]   = '0;
      rect_y[l]   = '0;
      rect_w[l]   = '0;
      rect_h[l]   = '0;
      rect_rgb[l] = '0;
    end
    fd = $fopen(TESTS_FILE, "r");
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    if (fd == 0) begin
      error_count++;
      $display("could not open %s for reading", TESTS_FILE);
    end else begin
      run_records(fd);
      $fclose(fd);
    end
    finish_run();
  end

endmodule

// ==== build.f ====
+incdir+.
screen_pkg.sv
vga_timing.sv
draw_screen_end.sv
draw_rect_layer.sv
vga_out.sv
screen_end_top.sv
screen_end_tb.sv

// ==== screen_end_tests.txt ====
# F  en x y w h rgb for each of the 3 layers, applied in the blanking before the next frame
# M  the same layer fields and then a change row, applied at that row of the current frame
# P  x y rgb, a probe and its expected colour, in raster order, x y decimal and colours hex
F 0 0 0 0 0 000  0 0 0 0 0 000  0 0 0 0 0 000
P 300 39 fff
P 39 40 fff   P 40 40 f00   P 300 40 ff0
P 70 100 000   P 100 100 0f0   P 200 100 00f
P 760 100 0f0   P 761 100 fff   P 770 100 fff   P 800 100 000
P 300 149 ff0
P 199 150 00f   P 200 150 fff
P 600 300 fff   P 601 300 0f0
P 300 450 fff
P 300 451 ff0
P 300 559 ff0
P 300 560 fff
P 100 600 000
F 1 100 120 60 40 5a5  1 140 140 50 30 a5a  1 620 420 60 40 0ff
P 99 120 0f0   P 100 120 5a5   P 159 120 5a5   P 160 120 f00
P 150 150 a5a
P 120 159 5a5
P 120 160 0f0
P 189 169 a5a   P 190 169 f00
P 150 170 ff0
P 650 200 00f
M 0 100 120 60 40 5a5  1 140 140 50 30 a5a  1 620 200 60 40 0ff  400
P 620 420 0ff
P 680 459 ff0
P 100 120 0f0
P 150 150 a5a
P 120 159 0f0
P 650 200 0ff
P 679 239 0ff   P 680 239 ff0
P 650 240 00f
P 650 420 00f
